// ==== src/pmp_config.svh ====
// --------------------
// Build-time sizing of the PMP unit
// --------------------

`ifndef PMP_CONFIG_SVH
`define PMP_CONFIG_SVH

// Number of implemented PMP entries
// Keep a power of two so the CSR index covers every entry
`define PMP_NUM_REGIONS 4

// NAPOT granularity G
// Smallest region is 2^(G+2) bytes
// 0 gives 4-byte granules
`define PMP_GRANULARITY 0

// Physical address width of a request
// pmpaddr registers hold bits PMP_ADDR_W-1 down to 2
`define PMP_ADDR_W 34

`endif

// ==== src/pmp_pkg.sv ====
// --------------------
// PMP types: match modes, access and privilege enums, CSR opcodes
// --------------------

package pmp_pkg;

  // --------------------
  // Entry match mode
  // --------------------
  // Encoding follows the A field of pmpcfg
  typedef enum logic [1:0] {
    PMP_MODE_OFF   = 2'b00,
    PMP_MODE_TOR   = 2'b01,
    PMP_MODE_NA4   = 2'b10,
    PMP_MODE_NAPOT = 2'b11
  } pmp_mode_e;

  // Access type of a memory request
  typedef enum logic [1:0] {
    PMP_ACC_EXEC  = 2'b00,
    PMP_ACC_WRITE = 2'b01,
    PMP_ACC_READ  = 2'b10
  } pmp_acc_e;

  // Privilege level of the requester
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // --------------------
  // One pmpcfg byte
  // --------------------
  // Bit 7 lock, bits 6:5 reserved, bits 4:3 mode, then X W R
  typedef struct packed {
    logic      lock;
    logic [1:0] rsvd;
    pmp_mode_e mode;
    logic      exec;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  // --------------------
  // CSR port opcode
  // --------------------
  // CFG selects pmpcfg of the indexed entry (byte in bits 7:0)
  // ADDR selects pmpaddr of the indexed entry
  //   pmpaddr holds physical address bits 33:2 in data bits 31:0
  // MSECCFG ignores the index
  //   Bit 0 MML, bit 1 MMWP, bit 2 RLB
  typedef enum logic [1:0] {
    PMP_CSR_CFG     = 2'b00,
    PMP_CSR_ADDR    = 2'b01,
    PMP_CSR_MSECCFG = 2'b10
  } pmp_csr_sel_e;

endpackage

// ==== src/pmp_csr.sv ====
// --------------------
// PMP register bank with lock, TOR-lock, MSECCFG and RLB write rules
// --------------------

`include "pmp_config.svh"

module pmp_csr (
  input  logic                                         clk,
  input  logic                                         rst_i,
  input  logic                                         csr_we_i,
  input  pmp_pkg::pmp_csr_sel_e                        csr_sel_i,
  input  logic [$clog2(`PMP_NUM_REGIONS)-1:0]          csr_idx_i,
  input  logic [31:0]                                  csr_wdata_i,
  output logic [31:0]                                  csr_rdata_o,
  output pmp_pkg::pmp_cfg_t [`PMP_NUM_REGIONS-1:0]     pmp_cfg_o,
  output logic [`PMP_NUM_REGIONS-1:0][`PMP_ADDR_W-1:2] pmp_addr_o,
  output logic                                         mml_o,
  output logic                                         mmwp_o
);

  localparam int N = `PMP_NUM_REGIONS;

  // Entry state
  pmp_pkg::pmp_cfg_t [N-1:0]       cfg_q;
  logic [N-1:0][`PMP_ADDR_W-1:2]   addr_q;
  // MSECCFG bits
  logic                            mml_q;
  logic                            mmwp_q;
  logic                            rlb_q;

  // Lock views per entry
  logic [N-1:0]                    lock_vec;
  logic [N-1:0]                    tor_lock;

  // Write qualification
  pmp_pkg::pmp_cfg_t               cfg_wdata;
  logic                            cfg_mml_refuse;
  logic                            cfg_wr_ok;
  logic                            addr_wr_ok;
  logic                            rlb_wr_ok;

  // --------------------
  // Lock decode
  // --------------------
  for (genvar i = 0; i < N; i++) begin : g_lock
    assign lock_vec[i] = cfg_q[i].lock;
    // Entry i+1 in locked TOR mode also freezes pmpaddr i
    if (i < N - 1) begin : g_tor
      assign tor_lock[i] = cfg_q[i+1].lock && (cfg_q[i+1].mode == pmp_pkg::PMP_MODE_TOR);
    end else begin : g_top
      assign tor_lock[i] = 1'b0;
    end
  end

  always_comb begin
    cfg_wdata      = pmp_pkg::pmp_cfg_t'(csr_wdata_i[7:0]);
    // Reserved field reads back as zero
    cfg_wdata.rsvd = 2'b00;
    // Under MML no new M-only executable or locked shared executable rule
    cfg_mml_refuse = mml_q && cfg_wdata.lock &&
                     ((cfg_wdata.exec && !(cfg_wdata.read && cfg_wdata.write)) ||
                      (cfg_wdata.write && !cfg_wdata.read));
    // RLB bypasses every entry lock rule
    cfg_wr_ok      = rlb_q || (!cfg_q[csr_idx_i].lock && !cfg_mml_refuse);
    addr_wr_ok     = rlb_q || !(cfg_q[csr_idx_i].lock || tor_lock[csr_idx_i]);
    // RLB frozen once any entry is locked with RLB clear
    rlb_wr_ok      = rlb_q || !(|lock_vec);
  end

  // --------------------
  // Register update
  // --------------------
  always_ff @(posedge clk) begin
    if (rst_i) begin
      cfg_q  <= '0;
      addr_q <= '0;
      mml_q  <= 1'b0;
      mmwp_q <= 1'b0;
      rlb_q  <= 1'b0;
    end else if (csr_we_i) begin
      case (csr_sel_i)
        pmp_pkg::PMP_CSR_CFG: begin
          if (cfg_wr_ok) begin
            cfg_q[csr_idx_i] <= cfg_wdata;
          end
        end
        pmp_pkg::PMP_CSR_ADDR: begin
          if (addr_wr_ok) begin
            addr_q[csr_idx_i] <= csr_wdata_i[`PMP_ADDR_W-3:0];
          end
        end
        pmp_pkg::PMP_CSR_MSECCFG: begin
          // MML and MMWP are sticky
          mml_q  <= mml_q | csr_wdata_i[0];
          mmwp_q <= mmwp_q | csr_wdata_i[1];
          if (rlb_wr_ok) begin
            rlb_q <= csr_wdata_i[2];
          end
        end
        default: ;
      endcase
    end
  end

  // Read port shows live state
  always_comb begin
    csr_rdata_o = '0;
    case (csr_sel_i)
      pmp_pkg::PMP_CSR_CFG:     csr_rdata_o[7:0] = cfg_q[csr_idx_i];
      pmp_pkg::PMP_CSR_ADDR:    csr_rdata_o      = addr_q[csr_idx_i];
      pmp_pkg::PMP_CSR_MSECCFG: csr_rdata_o[2:0] = {rlb_q, mmwp_q, mml_q};
      default: ;
    endcase
  end

  assign pmp_cfg_o  = cfg_q;
  assign pmp_addr_o = addr_q;
  assign mml_o      = mml_q;
  assign mmwp_o     = mmwp_q;

  // --------------------
  // Assertions
  // --------------------
  // Sticky MSECCFG bits drop only through reset
  a_mseccfg_sticky: assert property (@(posedge clk)
    ($fell(mml_q) || $fell(mmwp_q)) |-> $past(rst_i))
    else $error("MML or MMWP cleared without reset");

  a_idx_range: assert property (@(posedge clk) disable iff (rst_i)
    csr_we_i |-> (csr_idx_i < N))
    else $error("CSR index out of range");

endmodule

// ==== src/pmp_check.sv ====
// --------------------
// PMP region match and permission check giving the access fault
// --------------------

`include "pmp_config.svh"

module pmp_check #(
  parameter int NUM_REGIONS = 4,
  parameter int GRANULARITY = 0
) (
  input  pmp_pkg::pmp_cfg_t [NUM_REGIONS-1:0]      pmp_cfg_i,
  input  logic [NUM_REGIONS-1:0][`PMP_ADDR_W-1:2]  pmp_addr_i,
  input  logic                                     mml_i,
  input  logic                                     mmwp_i,
  input  pmp_pkg::priv_lvl_e                       priv_lvl_i,
  input  logic [`PMP_ADDR_W-1:0]                   req_addr_i,
  input  pmp_pkg::pmp_acc_e                        req_type_i,
  output logic                                     access_fault_o
);

  localparam int AW      = `PMP_ADDR_W;
  // Lowest address bit that the comparators look at
  localparam int LSB     = GRANULARITY + 2;
  // Lowest pmpaddr bit that takes part in NAPOT size decode
  localparam int MASK_LO = (GRANULARITY == 0) ? 2 : GRANULARITY + 1;

  // Per-entry match terms
  logic [NUM_REGIONS-1:0][AW-1:2]   start_addr;
  logic [NUM_REGIONS-1:0][AW-1:LSB] napot_mask;
  logic [NUM_REGIONS-1:0]           hit_eq;
  logic [NUM_REGIONS-1:0]           hit_gt;
  logic [NUM_REGIONS-1:0]           hit_lt;
  logic [NUM_REGIONS-1:0]           region_match;
  // Per-entry permission results
  logic [NUM_REGIONS-1:0]           perm_ok;
  logic [NUM_REGIONS-1:0]           mml_ok;

  // Request decode
  logic                             acc_r;
  logic                             acc_w;
  logic                             acc_x;
  logic                             priv_m;
  logic                             region_hit;
  logic                             fault;

  assign acc_r  = (req_type_i == pmp_pkg::PMP_ACC_READ);
  assign acc_w  = (req_type_i == pmp_pkg::PMP_ACC_WRITE);
  assign acc_x  = (req_type_i == pmp_pkg::PMP_ACC_EXEC);
  assign priv_m = (priv_lvl_i == pmp_pkg::PRIV_LVL_M);

  for (genvar r = 0; r < NUM_REGIONS; r++) begin : g_region
    pmp_pkg::pmp_cfg_t cfg;
    logic              is_tor;
    logic              is_napot;
    logic              match_l;
    logic              mml_l;

    assign cfg      = pmp_cfg_i[r];
    assign is_tor   = (cfg.mode == pmp_pkg::PMP_MODE_TOR);
    assign is_napot = (cfg.mode == pmp_pkg::PMP_MODE_NAPOT);

    // --------------------
    // Region bounds
    // --------------------
    // TOR lower bound is the previous pmpaddr, or zero for entry 0
    if (r == 0) begin : g_first
      assign start_addr[r] = is_tor ? '0 : pmp_addr_i[r];
    end else begin : g_next
      assign start_addr[r] = is_tor ? pmp_addr_i[r-1] : pmp_addr_i[r];
    end

    // NAPOT mask from the run of trailing ones in pmpaddr
    // A zero mask bit drops that address bit from the compare
    for (genvar b = LSB; b < AW; b++) begin : g_mask
      if (b == 2) begin : g_min
        // Smallest NAPOT region already spans bit 2
        assign napot_mask[r][b] = !is_napot;
      end else begin : g_upper
        assign napot_mask[r][b] = !is_napot || !(&pmp_addr_i[r][b-1:MASK_LO]);
      end
    end

    // Comparators sized to the granule
    assign hit_eq[r] = (req_addr_i[AW-1:LSB] & napot_mask[r]) ==
                       (start_addr[r][AW-1:LSB] & napot_mask[r]);
    assign hit_gt[r] = req_addr_i[AW-1:LSB] > start_addr[r][AW-1:LSB];
    assign hit_lt[r] = req_addr_i[AW-1:LSB] < pmp_addr_i[r][AW-1:LSB];

    always_comb begin
      case (cfg.mode)
        pmp_pkg::PMP_MODE_TOR:   match_l = (hit_eq[r] || hit_gt[r]) && hit_lt[r];
        pmp_pkg::PMP_MODE_NA4:   match_l = hit_eq[r];
        pmp_pkg::PMP_MODE_NAPOT: match_l = hit_eq[r];
        default:                 match_l = 1'b0;
      endcase
    end
    assign region_match[r] = match_l;

    // --------------------
    // Permissions
    // --------------------
    assign perm_ok[r] = (acc_r && cfg.read) || (acc_w && cfg.write) || (acc_x && cfg.exec);

    // Smepmp table keyed on L R W X
    always_comb begin
      case ({cfg.lock, cfg.read, cfg.write, cfg.exec})
        // Shared RW in M, read only below M
        4'b0010: mml_l = acc_r || (acc_w && priv_m);
        // Shared RW everywhere
        4'b0011: mml_l = acc_r || acc_w;
        // Shared execute only
        4'b1010: mml_l = acc_x;
        // Shared RX in M, execute only below M
        4'b1011: mml_l = acc_x || (acc_r && priv_m);
        // Shared read only
        4'b1111: mml_l = acc_r;
        // Locked rules belong to M and unlocked rules to S and U
        default: mml_l = priv_m ? (cfg.lock && perm_ok[r]) : (!cfg.lock && perm_ok[r]);
      endcase
    end
    assign mml_ok[r] = mml_l;
  end

  // --------------------
  // Priority select
  // --------------------
  // Lowest-numbered matching entry decides
  always_comb begin
    region_hit = 1'b0;
    // No match denies under MMWP or below M
    fault      = mmwp_i || !priv_m;
    for (int r = 0; r < NUM_REGIONS; r++) begin
      if (region_match[r] && !region_hit) begin
        region_hit = 1'b1;
        if (mml_i) begin
          fault = !mml_ok[r];
        end else if (priv_m) begin
          // M-mode bound only by locked entries
          fault = pmp_cfg_i[r].lock && !perm_ok[r];
        end else begin
          fault = !perm_ok[r];
        end
      end
    end
  end

  assign access_fault_o = fault;

  // Known register state and request must give a known decision
  always_comb begin
    if (!$isunknown({priv_lvl_i, req_type_i, req_addr_i, mml_i, mmwp_i,
                     pmp_cfg_i, pmp_addr_i})) begin
      a_fault_known: assert (!$isunknown(access_fault_o))
        else $error("access_fault_o is X for a known request");
    end
  end

endmodule

// ==== src/pmp_unit.sv ====
// --------------------
// PMP unit top joining register bank and checker
// --------------------

`include "pmp_config.svh"

module pmp_unit (
  input  logic                                clk,
  input  logic                                rst_i,
  // CSR channel
  input  logic                                csr_we_i,
  input  pmp_pkg::pmp_csr_sel_e               csr_sel_i,
  input  logic [$clog2(`PMP_NUM_REGIONS)-1:0] csr_idx_i,
  input  logic [31:0]                         csr_wdata_i,
  output logic [31:0]                         csr_rdata_o,
  // Request channel
  input  logic                                req_valid_i,
  input  logic [`PMP_ADDR_W-1:0]              req_addr_i,
  input  pmp_pkg::pmp_acc_e                   req_type_i,
  input  pmp_pkg::priv_lvl_e                  req_priv_i,
  output logic                                resp_valid_o,
  output logic                                resp_err_o
);

  // Register bank to checker
  pmp_pkg::pmp_cfg_t [`PMP_NUM_REGIONS-1:0]     pmp_cfg;
  logic [`PMP_NUM_REGIONS-1:0][`PMP_ADDR_W-1:2] pmp_addr;
  logic                                         mml;
  logic                                         mmwp;
  logic                                         access_fault;

  pmp_csr u_pmp_csr (
    .clk         (clk),
    .rst_i       (rst_i),
    .csr_we_i    (csr_we_i),
    .csr_sel_i   (csr_sel_i),
    .csr_idx_i   (csr_idx_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .pmp_cfg_o   (pmp_cfg),
    .pmp_addr_o  (pmp_addr),
    .mml_o       (mml),
    .mmwp_o      (mmwp)
  );

  // Decision uses state as seen in the request cycle
  pmp_check #(
    .NUM_REGIONS (`PMP_NUM_REGIONS),
    .GRANULARITY (`PMP_GRANULARITY)
  ) u_pmp_check (
    .pmp_cfg_i      (pmp_cfg),
    .pmp_addr_i     (pmp_addr),
    .mml_i          (mml),
    .mmwp_i         (mmwp),
    .priv_lvl_i     (req_priv_i),
    .req_addr_i     (req_addr_i),
    .req_type_i     (req_type_i),
    .access_fault_o (access_fault)
  );

  // --------------------
  // Response stage
  // --------------------
  // One cycle from request strobe to response strobe
  always_ff @(posedge clk) begin
    if (rst_i) begin
      resp_valid_o <= 1'b0;
      resp_err_o   <= 1'b0;
    end else begin
      resp_valid_o <= req_valid_i;
      // Error only meaningful alongside the strobe
      resp_err_o   <= req_valid_i && access_fault;
    end
  end

  a_resp_latency: assert property (@(posedge clk) disable iff (rst_i)
    !$past(rst_i) |-> (resp_valid_o == $past(req_valid_i)))
    else $error("resp_valid_o does not follow req_valid_i by one cycle");

endmodule

// ==== dv/pmp_unit_tb_vectors.svh ====
// --------------------
// Table of CSR writes, read-backs and requests with expected results
// --------------------

`ifndef PMP_UNIT_TB_VECTORS_SVH
`define PMP_UNIT_TB_VECTORS_SVH

// Rows: write_row(sel, idx, data), read_row(sel, idx, expected data)
//       request_row(addr, type, priv, expected err), reset_row()
task automatic load_table();
  // --------------------
  // Match modes, MML clear
  // --------------------
  // Entry 1 TOR covers 0x1000 up to 0x2000, read only
  write_row(ADDR, 0, 32'h0000_0400);
  write_row(ADDR, 1, 32'h0000_0800);
  write_row(CFG, 1, 32'h0000_0009);
  // Entry 2 NA4 covers 0x3000 to 0x3003, read only
  write_row(ADDR, 2, 32'h0000_0c00);
  write_row(CFG, 2, 32'h0000_0011);
  // Entry 3 NAPOT 256 bytes at 0x4000, read only
  write_row(ADDR, 3, 32'h0000_101f);
  write_row(CFG, 3, 32'h0000_0019);
  request_row(34'h0_1000, RD, PU, 0);
  request_row(34'h0_2000, RD, PU, 1);
  request_row(34'h0_0ffc, RD, PU, 1);
  request_row(34'h0_1800, WR, PU, 1);
  request_row(34'h0_3000, RD, PU, 0);
  request_row(34'h0_3004, RD, PU, 1);
  request_row(34'h0_40fc, RD, PU, 0);
  request_row(34'h0_4100, RD, PU, 1);
  request_row(34'h0_4080, WR, PU, 1);
  // Priority: entry 0 NA4 at 0x4040 with RW sits inside entry 3
  // Moving pmpaddr0 also empties the TOR range of entry 1
  write_row(ADDR, 0, 32'h0000_1010);
  write_row(CFG, 0, 32'h0000_0013);
  request_row(34'h0_4040, WR, PU, 0);
  request_row(34'h0_4044, WR, PU, 1);
  // --------------------
  // Default rule and lock
  // --------------------
  request_row(34'h0_8000, RD, PM, 0);
  request_row(34'h0_8000, RD, PU, 1);
  // Unlocked entry does not bind M-mode
  request_row(34'h0_4044, WR, PM, 0);
  write_row(CFG, 3, 32'h0000_0099);
  request_row(34'h0_4044, WR, PM, 1);
  // --------------------
  // Locked entries refuse writes
  // --------------------
  write_row(CFG, 3, 32'h0000_001f);
  read_row(CFG, 3, 32'h0000_0099);
  write_row(ADDR, 3, 32'h0000_2000);
  read_row(ADDR, 3, 32'h0000_101f);
  // Entry 2 locked in TOR mode freezes pmpaddr1
  write_row(CFG, 2, 32'h0000_0089);
  write_row(ADDR, 1, 32'h0000_0123);
  read_row(ADDR, 1, 32'h0000_0800);
  // RLB cannot be set while a lock is present
  write_row(MSEC, 0, 32'h0000_0004);
  read_row(MSEC, 0, 32'h0000_0000);
  reset_row();
  // RLB set with no lock, then locked entries accept writes
  write_row(MSEC, 0, 32'h0000_0004);
  write_row(CFG, 3, 32'h0000_0099);
  write_row(ADDR, 3, 32'h0000_2000);
  read_row(ADDR, 3, 32'h0000_2000);
  // Locked cfg byte also rewritable under RLB
  write_row(CFG, 3, 32'h0000_001f);
  read_row(CFG, 3, 32'h0000_001f);
  write_row(CFG, 2, 32'h0000_0089);
  write_row(ADDR, 1, 32'h0000_0900);
  read_row(ADDR, 1, 32'h0000_0900);
  // --------------------
  // MML rules
  // --------------------
  reset_row();
  // Entry 0 shared R=0 W=1 X=0 L=0, NAPOT 256 bytes at 0x4000
  write_row(ADDR, 0, 32'h0000_101f);
  write_row(CFG, 0, 32'h0000_001a);
  // Entry 1 locked read only NA4 at 0x5000, M-only under MML
  write_row(ADDR, 1, 32'h0000_1400);
  write_row(CFG, 1, 32'h0000_0091);
  // Entry 2 unlocked RW NA4 at 0x6000, S and U only under MML
  write_row(ADDR, 2, 32'h0000_1800);
  write_row(CFG, 2, 32'h0000_0013);
  write_row(MSEC, 0, 32'h0000_0001);
  // New locked executable rule is refused under MML
  write_row(CFG, 3, 32'h0000_009c);
  read_row(CFG, 3, 32'h0000_0000);
  request_row(34'h0_4000, RD, PM, 0);
  request_row(34'h0_4000, WR, PM, 0);
  request_row(34'h0_4000, RD, PU, 0);
  request_row(34'h0_4000, WR, PU, 1);
  request_row(34'h0_5000, RD, PM, 0);
  request_row(34'h0_5000, RD, PU, 1);
  request_row(34'h0_6000, RD, PM, 1);
  request_row(34'h0_6000, WR, PU, 0);
  // --------------------
  // MMWP is sticky and denies unmatched M-mode access
  // --------------------
  write_row(MSEC, 0, 32'h0000_0002);
  read_row(MSEC, 0, 32'h0000_0003);
  request_row(34'h0_8000, RD, PM, 1);
  write_row(MSEC, 0, 32'h0000_0000);
  read_row(MSEC, 0, 32'h0000_0003);
endtask

`endif

// ==== dv/pmp_unit_tb.sv ====
// --------------------
// PMP unit testbench: clock, reset, table runner, random requests
// --------------------

`include "pmp_config.svh"

module pmp_unit_tb;

  localparam int CLK_PERIOD = 8;
  localparam int IDX_W      = $clog2(`PMP_NUM_REGIONS);
  localparam int RAND_N     = 24;

  typedef enum logic [1:0] {
    ROW_WRITE,
    ROW_READ,
    ROW_REQ,
    ROW_RESET
  } row_kind_e;

  // One table row, data doubles as expected read data
  typedef struct packed {
    row_kind_e              kind;
    pmp_pkg::pmp_csr_sel_e  sel;
    logic [IDX_W-1:0]       idx;
    logic [31:0]            data;
    logic [`PMP_ADDR_W-1:0] addr;
    pmp_pkg::pmp_acc_e      acc;
    pmp_pkg::priv_lvl_e     priv;
    logic                   exp_err;
  } row_t;

  // Short names used by the table
  localparam pmp_pkg::pmp_csr_sel_e CFG  = pmp_pkg::PMP_CSR_CFG;
  localparam pmp_pkg::pmp_csr_sel_e ADDR = pmp_pkg::PMP_CSR_ADDR;
  localparam pmp_pkg::pmp_csr_sel_e MSEC = pmp_pkg::PMP_CSR_MSECCFG;
  localparam pmp_pkg::pmp_acc_e     RD   = pmp_pkg::PMP_ACC_READ;
  localparam pmp_pkg::pmp_acc_e     WR   = pmp_pkg::PMP_ACC_WRITE;
  localparam pmp_pkg::pmp_acc_e     EX   = pmp_pkg::PMP_ACC_EXEC;
  localparam pmp_pkg::priv_lvl_e    PU   = pmp_pkg::PRIV_LVL_U;
  localparam pmp_pkg::priv_lvl_e    PM   = pmp_pkg::PRIV_LVL_M;

  logic                   clk;
  logic                   rst_i;
  logic                   csr_we_i;
  pmp_pkg::pmp_csr_sel_e  csr_sel_i;
  logic [IDX_W-1:0]       csr_idx_i;
  logic [31:0]            csr_wdata_i;
  logic [31:0]            csr_rdata_o;
  logic                   req_valid_i;
  logic [`PMP_ADDR_W-1:0] req_addr_i;
  pmp_pkg::pmp_acc_e      req_type_i;
  pmp_pkg::priv_lvl_e     req_priv_i;
  logic                   resp_valid_o;
  logic                   resp_err_o;

  row_t   table_q[$];
  int     pass_cnt;
  int     fail_cnt;
  integer seed;

  pmp_unit u_pmp_unit (
    .clk          (clk),
    .rst_i        (rst_i),
    .csr_we_i     (csr_we_i),
    .csr_sel_i    (csr_sel_i),
    .csr_idx_i    (csr_idx_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_rdata_o  (csr_rdata_o),
    .req_valid_i  (req_valid_i),
    .req_addr_i   (req_addr_i),
    .req_type_i   (req_type_i),
    .req_priv_i   (req_priv_i),
    .resp_valid_o (resp_valid_o),
    .resp_err_o   (resp_err_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------
  // Table builders
  // --------------------
  task automatic write_row(input pmp_pkg::pmp_csr_sel_e sel, input logic [IDX_W-1:0] idx,
                           input logic [31:0] data);
    row_t row;
    row      = '0;
    row.kind = ROW_WRITE;
    row.sel  = sel;
    row.idx  = idx;
    row.data = data;
    table_q.push_back(row);
  endtask

  task automatic read_row(input pmp_pkg::pmp_csr_sel_e sel, input logic [IDX_W-1:0] idx,
                          input logic [31:0] exp_data);
    row_t row;
    row      = '0;
    row.kind = ROW_READ;
    row.sel  = sel;
    row.idx  = idx;
    row.data = exp_data;
    table_q.push_back(row);
  endtask

  task automatic request_row(input logic [`PMP_ADDR_W-1:0] addr, input pmp_pkg::pmp_acc_e acc,
                             input pmp_pkg::priv_lvl_e priv, input logic exp_err);
    row_t row;
    row         = '0;
    row.kind    = ROW_REQ;
    row.addr    = addr;
    row.acc     = acc;
    row.priv    = priv;
    row.exp_err = exp_err;
    table_q.push_back(row);
  endtask

  task automatic reset_row();
    row_t row;
    row      = '0;
    row.kind = ROW_RESET;
    table_q.push_back(row);
  endtask

  `include "pmp_unit_tb_vectors.svh"

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_err(input int num, input logic got, input logic exp_err,
                           input pmp_pkg::pmp_acc_e acc, input logic [`PMP_ADDR_W-1:0] addr);
    if (got === exp_err) begin
      pass_cnt++;
      $display("ok   test %0d: %s at %h err %b", num, acc.name(), addr, got);
    end else begin
      fail_cnt++;
      $display("FAIL t=%0t test %0d: %s at %h err %b, expected %b",
               $time, num, acc.name(), addr, got, exp_err);
    end
  endtask

  task automatic check_rdata(input int num, input logic [31:0] got, input logic [31:0] exp_data,
                             input pmp_pkg::pmp_csr_sel_e sel);
    if (got === exp_data) begin
      pass_cnt++;
      $display("ok   test %0d: read %s data %h", num, sel.name(), got);
    end else begin
      fail_cnt++;
      $display("FAIL t=%0t test %0d: read %s data %h, expected %h",
               $time, num, sel.name(), got, exp_data);
    end
  endtask

  // --------------------
  // Drivers, all entered on a falling edge
  // --------------------
  // Three rising edges with reset high, released on the next falling edge
  task automatic apply_reset();
    rst_i = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
  endtask

  // Response is due exactly one edge after the request strobe
  task automatic await_response(input int num, input logic exp_err,
                                input pmp_pkg::pmp_acc_e acc, input logic [`PMP_ADDR_W-1:0] addr);
    @(negedge clk);
    req_valid_i = 1'b0;
    if (resp_valid_o !== 1'b1) begin
      fail_cnt++;
      $display("Test %0d: no response strobe one cycle after the request to %h", num, addr);
    end else begin
      check_err(num, resp_err_o, exp_err, acc, addr);
    end
  endtask

  task automatic apply_row(input int num, input row_t row);
    case (row.kind)
      ROW_WRITE: begin
        csr_we_i    = 1'b1;
        csr_sel_i   = row.sel;
        csr_idx_i   = row.idx;
        csr_wdata_i = row.data;
        @(negedge clk);
        csr_we_i    = 1'b0;
      end
      ROW_READ: begin
        csr_sel_i = row.sel;
        csr_idx_i = row.idx;
        @(negedge clk);
        check_rdata(num, csr_rdata_o, row.data, row.sel);
      end
      ROW_REQ: begin
        req_valid_i = 1'b1;
        req_addr_i  = row.addr;
        req_type_i  = row.acc;
        req_priv_i  = row.priv;
        await_response(num, row.exp_err, row.acc, row.addr);
      end
      default: apply_reset();
    endcase
  endtask

  // Back-to-back U-mode requests with every entry OFF, all must fault
  task automatic random_requests(input int first_num);
    logic [31:0]       r;
    pmp_pkg::pmp_acc_e acc;
    for (int i = 0; i < RAND_N; i++) begin
      r = $random(seed);
      case (r[1:0])
        2'd0: acc = EX;
        2'd1: acc = WR;
        default: acc = RD;
      endcase
      req_valid_i = 1'b1;
      req_addr_i  = {r[3:2], $random(seed)};
      req_type_i  = acc;
      req_priv_i  = PU;
      await_response(first_num + i, 1'b1, acc, req_addr_i);
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    rst_i       = 1'b1;
    csr_we_i    = 1'b0;
    csr_sel_i   = CFG;
    csr_idx_i   = '0;
    csr_wdata_i = '0;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    req_type_i  = RD;
    req_priv_i  = PM;
    pass_cnt    = 0;
    fail_cnt    = 0;
    seed        = 32'h2da;
    load_table();
    apply_reset();
    foreach (table_q[i]) begin
      apply_row(i, table_q[i]);
    end
    // Clean state for the random pass
    apply_reset();
    random_requests(table_q.size());
    $display("Summary: %0d checks passed, %0d checks failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the table and the random pass
  initial begin
    int limit;
    #1;
    limit = (table_q.size() + RAND_N) * 10 * CLK_PERIOD;
    #(limit);
    $display("Timeout: the run did not finish within %0d time units", limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== pmp_unit.f ====
+incdir+src
+incdir+dv
src/pmp_pkg.sv
src/pmp_csr.sv
src/pmp_check.sv
src/pmp_unit.sv
dv/pmp_unit_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = pmp_unit_tb
FILELIST  = pmp_unit.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
